// File: rip_memory.f
+incdir+src
src/rip_mem_pkg.sv
src/rip_axi_lite_pkg.sv
src/rip_memory_management_unit.sv
src/rip_axi_lite_master.sv
src/rip_axi_lite_ram.sv
src/rip_memory_subsystem.sv
testbench/rip_clock_gen.sv
testbench/tb_rip_memory.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_rip_memory \
		-f rip_memory.f -Mdir obj_dir
	./obj_dir/Vtb_rip_memory | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_rip_memory.sv
`default_nettype none

`include "rip_consts.svh"

module tb_rip_memory;

    localparam int DW          = `RIP_DATA_WIDTH;
    localparam int AW          = `RIP_ADDR_WIDTH;
    localparam int BW          = `RIP_B_WIDTH;
    localparam int NBYTES      = DW / BW;
    localparam int OFS         = $clog2(NBYTES);
    localparam int IDX_W       = $clog2(`RIP_RAM_WORDS);
    localparam int N_DIRECTED  = 14;
    localparam int N_RANDOM    = 24;
    localparam int N_ENTRIES   = N_DIRECTED + N_RANDOM;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 5;

    // operation of one table entry
    localparam logic [1:0] OP_WR1  = 2'd0;
    localparam logic [1:0] OP_RD1  = 2'd1;
    localparam logic [1:0] OP_RD2  = 2'd2;
    localparam logic [1:0] OP_RD12 = 2'd3;

    wire                clk;
    wire                rstn;
    rip_mem_pkg::strb_t we_1;
    logic               re_1;
    logic [AW-1:0]      addr_1;
    logic [DW-1:0]      din_1;
    wire  [DW-1:0]      dout_1;
    wire                busy_1;
    logic               re_2;
    logic [AW-1:0]      addr_2;
    wire  [DW-1:0]      dout_2;
    wire                busy_2;

    // stimulus table; exp columns are the dout values expected after each entry
    logic [1:0]         t_op    [N_ENTRIES];
    logic [AW-1:0]      t_addr1 [N_ENTRIES];
    logic [AW-1:0]      t_addr2 [N_ENTRIES];
    logic [DW-1:0]      t_data  [N_ENTRIES];
    rip_mem_pkg::strb_t t_strb  [N_ENTRIES];
    logic [DW-1:0]      t_exp1  [N_ENTRIES];
    logic [DW-1:0]      t_exp2  [N_ENTRIES];

    // reference memory model
    logic [DW-1:0] model [`RIP_RAM_WORDS];

    integer seed;
    string  phase;

    rip_clock_gen clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    rip_memory_subsystem uut (
        .clk    (clk),
        .rstn   (rstn),
        .we_1   (we_1),
        .re_1   (re_1),
        .addr_1 (addr_1),
        .din_1  (din_1),
        .dout_1 (dout_1),
        .busy_1 (busy_1),
        .re_2   (re_2),
        .addr_2 (addr_2),
        .dout_2 (dout_2),
        .busy_2 (busy_2)
    );

    // word index taken from the bits just above the byte offset
    function automatic logic [IDX_W-1:0] word_index(input logic [AW-1:0] addr);
        return addr[IDX_W+OFS-1:OFS];
    endfunction

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_word,
                                                  input logic [DW-1:0] new_word,
                                                  input rip_mem_pkg::strb_t strb);
        logic [DW-1:0] result;
        result = old_word;
        for (int b = 0; b < NBYTES; b++) begin
            if (strb[b]) begin
                result[b*BW +: BW] = new_word[b*BW +: BW];
            end
        end
        return result;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("mismatch %s: got %h expected %h during %s",
                               name, got, exp, phase));
        end
    endtask

    task automatic set_entry(input int i, input logic [1:0] op,
                             input logic [AW-1:0] a1, input logic [AW-1:0] a2,
                             input logic [DW-1:0] data, input rip_mem_pkg::strb_t strb);
        t_op[i]    = op;
        t_addr1[i] = a1;
        t_addr2[i] = a2;
        t_data[i]  = data;
        t_strb[i]  = strb;
    endtask

    task automatic build_table();
        logic [31:0] r;
        // reads straight after reset see zero
        set_entry(0, OP_RD1, 32'h0000_0010, '0, '0, '0);
        set_entry(1, OP_RD2, '0, 32'h8000_0ffc, '0, '0);
        // full word write and read back
        set_entry(2, OP_WR1, 32'h0000_0100, '0, 32'hdead_beef, 4'hf);
        set_entry(3, OP_RD1, 32'h0000_0100, '0, '0, '0);
        // partial strobes, read back through port 2
        set_entry(4, OP_WR1, 32'h0000_0200, '0, 32'h1122_3344, 4'hf);
        set_entry(5, OP_WR1, 32'h0000_0200, '0, 32'haabb_ccdd, 4'b0101);
        set_entry(6, OP_RD2, '0, 32'h0000_0200, '0, '0);
        set_entry(7, OP_WR1, 32'h0000_0204, '0, 32'hcafe_f00d, 4'b1000);
        set_entry(8, OP_RD2, '0, 32'h0000_0204, '0, '0);
        // both ports in the same cycle
        set_entry(9, OP_RD12, 32'h0000_0204, 32'h0000_0200, '0, '0);
        // addresses beyond the ram depth wrap
        set_entry(10, OP_WR1, 32'h0000_1300, '0, 32'h5a5a_1234, 4'hf);
        set_entry(11, OP_RD2, '0, 32'h0000_0300, '0, '0);
        set_entry(12, OP_RD1, 32'hffff_f300, '0, '0, '0);
        set_entry(13, OP_RD12, 32'h0000_2204, 32'h0000_1200, '0, '0);

        // random block over a small window so reads hit earlier writes
        for (int i = N_DIRECTED; i < N_ENTRIES; i++) begin
            r          = $random(seed);
            t_op[i]    = r[1:0];
            t_addr1[i] = {r[31:28], 18'd0, 4'h4, r[5:2], 2'b00};
            t_addr2[i] = {r[27:24], 18'd0, 4'h4, r[9:6], 2'b00};
            t_strb[i]  = r[15:12];
            if (t_strb[i] == '0) begin
                t_strb[i] = 4'hf;
            end
            t_data[i] = $random(seed);
        end
    endtask

    task automatic fill_expected();
        logic [DW-1:0] last_1;
        logic [DW-1:0] last_2;
        last_1 = '0;
        last_2 = '0;
        for (int w = 0; w < `RIP_RAM_WORDS; w++) begin
            model[w] = '0;
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (t_op[i] == OP_WR1) begin
                model[word_index(t_addr1[i])] =
                    merge_bytes(model[word_index(t_addr1[i])], t_data[i], t_strb[i]);
            end
            if (t_op[i] == OP_RD1 || t_op[i] == OP_RD12) begin
                last_1 = model[word_index(t_addr1[i])];
            end
            if (t_op[i] == OP_RD2 || t_op[i] == OP_RD12) begin
                last_2 = model[word_index(t_addr2[i])];
            end
            // dout holds its last read word across other operations
            t_exp1[i] = last_1;
            t_exp2[i] = last_2;
        end
    endtask

    task automatic run_entry(input int i);
        logic want_1;
        logic want_2;
        int   cyc;
        int   fall_1;
        int   fall_2;
        want_1 = (t_op[i] != OP_RD2);
        want_2 = (t_op[i] == OP_RD2 || t_op[i] == OP_RD12);

        @(posedge clk);
        #DRIVE_DELAY;
        addr_1 = t_addr1[i];
        addr_2 = t_addr2[i];
        din_1  = t_data[i];
        we_1   = (t_op[i] == OP_WR1) ? t_strb[i] : '0;
        re_1   = (t_op[i] == OP_RD1 || t_op[i] == OP_RD12);
        re_2   = want_2;

        // one cycle pulse on the enables
        @(posedge clk);
        #DRIVE_DELAY;
        we_1 = '0;
        re_1 = 1'b0;
        re_2 = 1'b0;
        assert (!want_1 || busy_1) else begin
            fail_run($sformatf("port 1 did not go busy after its request in %s", phase));
        end
        assert (!want_2 || busy_2) else begin
            fail_run($sformatf("port 2 did not go busy after its request in %s", phase));
        end

        // note the cycle on which each busy is first seen low
        cyc    = 0;
        fall_1 = 0;
        fall_2 = 0;
        while (busy_1 || busy_2) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cyc++;
            if (!busy_1 && fall_1 == 0) begin
                fall_1 = cyc;
            end
            if (!busy_2 && fall_2 == 0) begin
                fall_2 = cyc;
            end
        end

        check_word("dout_1", dout_1, t_exp1[i]);
        check_word("dout_2", dout_2, t_exp2[i]);
        if (t_op[i] == OP_RD12) begin
            assert (fall_1 <= fall_2) else begin
                fail_run($sformatf("port 2 read finished before port 1 read in %s", phase));
            end
        end
    endtask

    // watchdog sized from the table length
    initial begin
        #(N_ENTRIES * 40 * CLK_PERIOD);
        fail_run("timeout: the testbench did not finish within its time budget");
    end

    initial begin
        seed   = 15320;
        we_1   = '0;
        re_1   = 1'b0;
        addr_1 = '0;
        din_1  = '0;
        re_2   = 1'b0;
        addr_2 = '0;
        phase  = "reset";

        build_table();
        fill_expected();

        wait (rstn === 1'b1);
        @(posedge clk);
        #DRIVE_DELAY;
        check_word("busy_1", {31'd0, busy_1}, '0);
        check_word("busy_2", {31'd0, busy_2}, '0);
        check_word("dout_1", dout_1, '0);
        check_word("dout_2", dout_2, '0);

        for (int i = 0; i < N_ENTRIES; i++) begin
            phase = $sformatf("entry %0d", i);
            run_entry(i);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/rip_clock_gen.sv
`default_nettype none

module rip_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held over the first edges, released just after the last one
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: src/rip_memory_subsystem.sv
`default_nettype none

`include "rip_consts.svh"

module rip_memory_subsystem (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire rip_mem_pkg::strb_t     we_1,
    input  wire                         re_1,
    input  wire [`RIP_ADDR_WIDTH-1:0]   addr_1,
    input  wire [`RIP_DATA_WIDTH-1:0]   din_1,
    output wire [`RIP_DATA_WIDTH-1:0]   dout_1,
    output wire                         busy_1,
    input  wire                         re_2,
    input  wire [`RIP_ADDR_WIDTH-1:0]   addr_2,
    output wire [`RIP_DATA_WIDTH-1:0]   dout_2,
    output wire                         busy_2
);

    // unit to master
    wire [`RIP_ADDR_WIDTH-1:0] raddr;
    wire                       rvalid;
    wire                       rready;
    wire [`RIP_DATA_WIDTH-1:0] rdata;
    wire                       rdone;
    wire [`RIP_ADDR_WIDTH-1:0] waddr;
    wire [`RIP_DATA_WIDTH-1:0] wdata;
    wire rip_mem_pkg::strb_t   wstrb;
    wire                       wvalid;
    wire                       wready;
    wire                       wdone;

    // master to ram
    wire [`RIP_ADDR_WIDTH-1:0]      axi_awaddr;
    wire                            axi_awvalid;
    wire                            axi_awready;
    wire [`RIP_DATA_WIDTH-1:0]      axi_wdata;
    wire rip_mem_pkg::strb_t        axi_wstrb;
    wire                            axi_wvalid;
    wire                            axi_wready;
    wire rip_axi_lite_pkg::resp_t   axi_bresp;
    wire                            axi_bvalid;
    wire                            axi_bready;
    wire [`RIP_ADDR_WIDTH-1:0]      axi_araddr;
    wire                            axi_arvalid;
    wire                            axi_arready;
    wire [`RIP_DATA_WIDTH-1:0]      axi_rdata;
    wire rip_axi_lite_pkg::resp_t   axi_rresp;
    wire                            axi_rvalid;
    wire                            axi_rready;

    rip_memory_management_unit mmu (
        .clk    (clk),
        .rstn   (rstn),
        .we_1   (we_1),
        .re_1   (re_1),
        .addr_1 (addr_1),
        .din_1  (din_1),
        .dout_1 (dout_1),
        .busy_1 (busy_1),
        .re_2   (re_2),
        .addr_2 (addr_2),
        .dout_2 (dout_2),
        .busy_2 (busy_2),
        .raddr  (raddr),
        .rvalid (rvalid),
        .rready (rready),
        .rdata  (rdata),
        .rdone  (rdone),
        .waddr  (waddr),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .wvalid (wvalid),
        .wready (wready),
        .wdone  (wdone)
    );

    rip_axi_lite_master axim (
        .clk        (clk),
        .rstn       (rstn),
        .raddr      (raddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rdone      (rdone),
        .waddr      (waddr),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdone      (wdone),
        .awaddr     (axi_awaddr),
        .awvalid    (axi_awvalid),
        .awready    (axi_awready),
        .wdata_axi  (axi_wdata),
        .wstrb_axi  (axi_wstrb),
        .wvalid_axi (axi_wvalid),
        .wready_axi (axi_wready),
        .bresp      (axi_bresp),
        .bvalid     (axi_bvalid),
        .bready     (axi_bready),
        .araddr     (axi_araddr),
        .arvalid    (axi_arvalid),
        .arready    (axi_arready),
        .rdata_axi  (axi_rdata),
        .rresp      (axi_rresp),
        .rvalid_axi (axi_rvalid),
        .rready_axi (axi_rready)
    );

    rip_axi_lite_ram ram (
        .clk       (clk),
        .rstn      (rstn),
        .s_awaddr  (axi_awaddr),
        .s_awvalid (axi_awvalid),
        .s_awready (axi_awready),
        .s_wdata   (axi_wdata),
        .s_wstrb   (axi_wstrb),
        .s_wvalid  (axi_wvalid),
        .s_wready  (axi_wready),
        .s_bresp   (axi_bresp),
        .s_bvalid  (axi_bvalid),
        .s_bready  (axi_bready),
        .s_araddr  (axi_araddr),
        .s_arvalid (axi_arvalid),
        .s_arready (axi_arready),
        .s_rdata   (axi_rdata),
        .s_rresp   (axi_rresp),
        .s_rvalid  (axi_rvalid),
        .s_rready  (axi_rready)
    );

endmodule

`default_nettype wire

// File: src/rip_axi_lite_ram.sv
`default_nettype none

`include "rip_consts.svh"

module rip_axi_lite_ram (
    input  wire                            clk,
    input  wire                            rstn,
    // write address and data
    input  wire [`RIP_ADDR_WIDTH-1:0]      s_awaddr,
    input  wire                            s_awvalid,
    output logic                           s_awready,
    input  wire [`RIP_DATA_WIDTH-1:0]      s_wdata,
    input  wire rip_mem_pkg::strb_t        s_wstrb,
    input  wire                            s_wvalid,
    output logic                           s_wready,
    // write response
    output rip_axi_lite_pkg::resp_t        s_bresp,
    output logic                           s_bvalid,
    input  wire                            s_bready,
    // read address and data
    input  wire [`RIP_ADDR_WIDTH-1:0]      s_araddr,
    input  wire                            s_arvalid,
    output logic                           s_arready,
    output logic [`RIP_DATA_WIDTH-1:0]     s_rdata,
    output rip_axi_lite_pkg::resp_t        s_rresp,
    output logic                           s_rvalid,
    input  wire                            s_rready
);

    localparam int NBYTES = `RIP_DATA_WIDTH / `RIP_B_WIDTH;
    localparam int OFS    = $clog2(NBYTES);
    localparam int IDX_W  = $clog2(`RIP_RAM_WORDS);

    logic [`RIP_DATA_WIDTH-1:0] mem [`RIP_RAM_WORDS];

    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;
    logic             wr_take;

    // upper address bits ignored, so addresses wrap
    assign widx = s_awaddr[IDX_W+OFS-1:OFS];
    assign ridx = s_araddr[IDX_W+OFS-1:OFS];

    // aw and w taken together, held off while a b response is pending
    assign wr_take   = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready = wr_take;
    assign s_wready  = wr_take;
    assign s_arready = !s_rvalid;

    assign s_bresp = rip_axi_lite_pkg::RESP_OKAY;
    assign s_rresp = rip_axi_lite_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `RIP_RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
            s_bvalid <= 1'b0;
            s_rvalid <= 1'b0;
        end else begin
            if (wr_take) begin
                for (int b = 0; b < NBYTES; b++) begin
                    if (s_wstrb[b]) begin
                        mem[widx][b*`RIP_B_WIDTH +: `RIP_B_WIDTH] <=
                            s_wdata[b*`RIP_B_WIDTH +: `RIP_B_WIDTH];
                    end
                end
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end

            // read response buffered until the master takes it
            if (s_arvalid && s_arready) begin
                s_rdata  <= mem[ridx];
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rip_axi_lite_master.sv
`default_nettype none

`include "rip_consts.svh"

module rip_axi_lite_master (
    input  wire                          clk,
    input  wire                          rstn,
    // read transfer from the unit
    input  wire [`RIP_ADDR_WIDTH-1:0]    raddr,
    input  wire                          rvalid,
    output logic                         rready,
    output logic [`RIP_DATA_WIDTH-1:0]   rdata,
    output logic                         rdone,
    // write transfer from the unit
    input  wire [`RIP_ADDR_WIDTH-1:0]    waddr,
    input  wire [`RIP_DATA_WIDTH-1:0]    wdata,
    input  wire rip_mem_pkg::strb_t      wstrb,
    input  wire                          wvalid,
    output logic                         wready,
    output logic                         wdone,
    // axi4-lite write address and data
    output logic [`RIP_ADDR_WIDTH-1:0]   awaddr,
    output logic                         awvalid,
    input  wire                          awready,
    output logic [`RIP_DATA_WIDTH-1:0]   wdata_axi,
    output rip_mem_pkg::strb_t           wstrb_axi,
    output logic                         wvalid_axi,
    input  wire                          wready_axi,
    // axi4-lite write response
    input  wire rip_axi_lite_pkg::resp_t bresp,
    input  wire                          bvalid,
    output logic                         bready,
    // axi4-lite read
    output logic [`RIP_ADDR_WIDTH-1:0]   araddr,
    output logic                         arvalid,
    input  wire                          arready,
    input  wire [`RIP_DATA_WIDTH-1:0]    rdata_axi,
    input  wire rip_axi_lite_pkg::resp_t rresp,
    input  wire                          rvalid_axi,
    output logic                         rready_axi
);

    rip_axi_lite_pkg::xfer_state_t rd_st;
    rip_axi_lite_pkg::xfer_state_t wr_st;

    // a new transfer is only taken on an idle channel
    assign rready = (rd_st == rip_axi_lite_pkg::XFER_IDLE);
    assign wready = (wr_st == rip_axi_lite_pkg::XFER_IDLE);

    // responses are never stalled; bresp and rresp are always OKAY from the ram
    assign bready     = 1'b1;
    assign rready_axi = 1'b1;

    // read channel
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_st   <= rip_axi_lite_pkg::XFER_IDLE;
            arvalid <= 1'b0;
            rdone   <= 1'b0;
        end else begin
            rdone <= 1'b0;
            case (rd_st)
                rip_axi_lite_pkg::XFER_IDLE: begin
                    if (rvalid) begin
                        araddr  <= raddr;
                        arvalid <= 1'b1;
                        rd_st   <= rip_axi_lite_pkg::XFER_ADDR;
                    end
                end
                rip_axi_lite_pkg::XFER_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rd_st   <= rip_axi_lite_pkg::XFER_RESP;
                    end
                end
                default: begin
                    if (rvalid_axi) begin
                        rdata <= rdata_axi;
                        rdone <= 1'b1;
                        rd_st <= rip_axi_lite_pkg::XFER_IDLE;
                    end
                end
            endcase
        end
    end

    // write channel, aw and w accepted independently
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_st      <= rip_axi_lite_pkg::XFER_IDLE;
            awvalid    <= 1'b0;
            wvalid_axi <= 1'b0;
            wdone      <= 1'b0;
        end else begin
            wdone <= 1'b0;
            case (wr_st)
                rip_axi_lite_pkg::XFER_IDLE: begin
                    if (wvalid) begin
                        awaddr     <= waddr;
                        wdata_axi  <= wdata;
                        wstrb_axi  <= wstrb;
                        awvalid    <= 1'b1;
                        wvalid_axi <= 1'b1;
                        wr_st      <= rip_axi_lite_pkg::XFER_ADDR;
                    end
                end
                rip_axi_lite_pkg::XFER_ADDR: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready_axi) begin
                        wvalid_axi <= 1'b0;
                    end
                    // both sides accepted, now or earlier
                    if ((!awvalid || awready) && (!wvalid_axi || wready_axi)) begin
                        wr_st <= rip_axi_lite_pkg::XFER_RESP;
                    end
                end
                default: begin
                    if (bvalid) begin
                        wdone <= 1'b1;
                        wr_st <= rip_axi_lite_pkg::XFER_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/rip_memory_management_unit.sv
`default_nettype none

`include "rip_consts.svh"

module rip_memory_management_unit (
    input  wire                        clk,
    input  wire                        rstn,
    // port 1, data side
    input  wire rip_mem_pkg::strb_t    we_1,
    input  wire                        re_1,
    input  wire [`RIP_ADDR_WIDTH-1:0]  addr_1,
    input  wire [`RIP_DATA_WIDTH-1:0]  din_1,
    output logic [`RIP_DATA_WIDTH-1:0] dout_1,
    output logic                       busy_1,
    // port 2, instruction fetch
    input  wire                        re_2,
    input  wire [`RIP_ADDR_WIDTH-1:0]  addr_2,
    output logic [`RIP_DATA_WIDTH-1:0] dout_2,
    output logic                       busy_2,
    // read transfer channel
    output logic [`RIP_ADDR_WIDTH-1:0] raddr,
    output logic                       rvalid,
    input  wire                        rready,
    input  wire [`RIP_DATA_WIDTH-1:0]  rdata,
    input  wire                        rdone,
    // write transfer channel
    output logic [`RIP_ADDR_WIDTH-1:0] waddr,
    output logic [`RIP_DATA_WIDTH-1:0] wdata,
    output rip_mem_pkg::strb_t         wstrb,
    output logic                       wvalid,
    input  wire                        wready,
    input  wire                        wdone
);

    rip_mem_pkg::port_state_t st_1;
    rip_mem_pkg::port_state_t st_2;

    // port 1 request in flight is a write
    logic                       p1_write;
    logic [`RIP_ADDR_WIDTH-1:0] park_1;
    logic [`RIP_ADDR_WIDTH-1:0] park_2;

    logic own_1;
    logic own_2;
    logic fresh_1;
    logic fresh_2;
    logic start_w1;
    logic grant_1;
    logic grant_2;

    assign busy_1 = (st_1 != rip_mem_pkg::PORT_IDLE);
    assign busy_2 = (st_2 != rip_mem_pkg::PORT_IDLE);

    // read channel arbitration
    always_comb begin
        own_1 = !p1_write && (st_1 == rip_mem_pkg::PORT_WAIT_ACCEPT ||
                              st_1 == rip_mem_pkg::PORT_WAIT_DONE);
        own_2 = (st_2 == rip_mem_pkg::PORT_WAIT_ACCEPT ||
                 st_2 == rip_mem_pkg::PORT_WAIT_DONE);
        start_w1 = (st_1 == rip_mem_pkg::PORT_IDLE) && (we_1 != '0);
        fresh_1  = (st_1 == rip_mem_pkg::PORT_IDLE) && (we_1 == '0) && re_1;
        fresh_2  = (st_2 == rip_mem_pkg::PORT_IDLE) && re_2;
        grant_1  = 1'b0;
        grant_2  = 1'b0;
        if (!own_1 && !own_2) begin
            // a parked port 2 read goes before any new port 1 read
            if (st_2 == rip_mem_pkg::PORT_WAIT_OTHER) begin
                grant_2 = 1'b1;
            end else if (fresh_1 || st_1 == rip_mem_pkg::PORT_WAIT_OTHER) begin
                grant_1 = 1'b1;
            end else begin
                grant_2 = fresh_2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            st_1     <= rip_mem_pkg::PORT_IDLE;
            st_2     <= rip_mem_pkg::PORT_IDLE;
            p1_write <= 1'b0;
            rvalid   <= 1'b0;
            wvalid   <= 1'b0;
            dout_1   <= '0;
            dout_2   <= '0;
        end else begin
            // port 1
            case (st_1)
                rip_mem_pkg::PORT_IDLE: begin
                    if (start_w1) begin
                        p1_write <= 1'b1;
                        wvalid   <= 1'b1;
                        st_1     <= rip_mem_pkg::PORT_WAIT_ACCEPT;
                    end else if (fresh_1) begin
                        p1_write <= 1'b0;
                        st_1     <= grant_1 ? rip_mem_pkg::PORT_WAIT_ACCEPT
                                            : rip_mem_pkg::PORT_WAIT_OTHER;
                    end
                end
                rip_mem_pkg::PORT_WAIT_OTHER: begin
                    if (grant_1) begin
                        st_1 <= rip_mem_pkg::PORT_WAIT_ACCEPT;
                    end
                end
                rip_mem_pkg::PORT_WAIT_ACCEPT: begin
                    if (p1_write && wready) begin
                        wvalid <= 1'b0;
                        st_1   <= rip_mem_pkg::PORT_WAIT_DONE;
                    end else if (!p1_write && rready) begin
                        st_1 <= rip_mem_pkg::PORT_WAIT_DONE;
                    end
                end
                default: begin
                    if (p1_write && wdone) begin
                        st_1 <= rip_mem_pkg::PORT_IDLE;
                    end else if (!p1_write && rdone) begin
                        dout_1 <= rdata;
                        st_1   <= rip_mem_pkg::PORT_IDLE;
                    end
                end
            endcase

            // port 2, reads only
            case (st_2)
                rip_mem_pkg::PORT_IDLE: begin
                    if (fresh_2) begin
                        st_2 <= grant_2 ? rip_mem_pkg::PORT_WAIT_ACCEPT
                                        : rip_mem_pkg::PORT_WAIT_OTHER;
                    end
                end
                rip_mem_pkg::PORT_WAIT_OTHER: begin
                    if (grant_2) begin
                        st_2 <= rip_mem_pkg::PORT_WAIT_ACCEPT;
                    end
                end
                rip_mem_pkg::PORT_WAIT_ACCEPT: begin
                    if (rready) begin
                        st_2 <= rip_mem_pkg::PORT_WAIT_DONE;
                    end
                end
                default: begin
                    if (rdone) begin
                        dout_2 <= rdata;
                        st_2   <= rip_mem_pkg::PORT_IDLE;
                    end
                end
            endcase

            // one read request toward the master at a time
            if (grant_1 || grant_2) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // request payloads
    always_ff @(posedge clk) begin
        if (start_w1) begin
            waddr <= addr_1;
            wdata <= din_1;
            wstrb <= we_1;
        end
        if (fresh_1) begin
            park_1 <= addr_1;
        end
        if (fresh_2) begin
            park_2 <= addr_2;
        end
        if (grant_1) begin
            raddr <= fresh_1 ? addr_1 : park_1;
        end else if (grant_2) begin
            raddr <= fresh_2 ? addr_2 : park_2;
        end
    end

endmodule

`default_nettype wire

// File: src/rip_axi_lite_pkg.sv
`default_nettype none

package rip_axi_lite_pkg;

    // bresp / rresp encoding
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // per-channel progress of the bus master
    typedef enum logic [1:0] {
        XFER_IDLE = 2'd0,
        XFER_ADDR = 2'd1,
        XFER_RESP = 2'd2
    } xfer_state_t;

endpackage

`default_nettype wire

// File: src/rip_mem_pkg.sv
`default_nettype none

`include "rip_consts.svh"

package rip_mem_pkg;

    // one enable bit per byte of a data word
    typedef logic [`RIP_DATA_WIDTH/`RIP_B_WIDTH-1:0] strb_t;

    // request progress of one core port
    typedef enum logic [1:0] {
        PORT_IDLE        = 2'd0,
        PORT_WAIT_OTHER  = 2'd1,
        PORT_WAIT_ACCEPT = 2'd2,
        PORT_WAIT_DONE   = 2'd3
    } port_state_t;

endpackage

`default_nettype wire

// File: src/rip_consts.svh
`ifndef RIP_CONSTS_SVH
`define RIP_CONSTS_SVH

// core address and data widths
`define RIP_ADDR_WIDTH 32
`define RIP_DATA_WIDTH 32
`define RIP_B_WIDTH 8

// ram depth in words, indexed by address bits above the byte offset
`define RIP_RAM_WORDS 1024

`endif
